// File: hdl/pipePkg.sv
`default_nettype none

package pipePkg;

	localparam int RegAddrW = 5;
	localparam int DataW = 32;
	localparam int InstW = 32;
	localparam int OpW = 4;
	localparam int ImmW = 13;

	// Instruction field positions
	localparam int OpMsb = 31;
	localparam int RdLsb = 23;
	localparam int RsLsb = 18;
	localparam int RtLsb = 13;

	localparam logic [OpW-1:0] OpNop = 4'h0;
	localparam logic [OpW-1:0] OpAdd = 4'h1;
	localparam logic [OpW-1:0] OpSub = 4'h2;
	localparam logic [OpW-1:0] OpAddi = 4'h3;
	localparam logic [OpW-1:0] OpLw = 4'h4;
	localparam logic [OpW-1:0] OpSw = 4'h5;

	localparam logic [1:0] FwdNone = 2'b00;	// Register file value
	localparam logic [1:0] FwdMem1 = 2'b01;
	localparam logic [1:0] FwdMem2 = 2'b10;
	localparam logic [1:0] FwdWb = 2'b11;

endpackage

`default_nettype wire

// File: hdl/instDecode.sv
`timescale 1ns/1ps
`default_nettype none

module instDecode (
	input wire clk,
	input wire rst_sign,
	input wire instValid,
	input wire [pipePkg::InstW-1:0] instWord,
	input wire idWr,
	output logic instReady,
	output logic idValid,
	output logic [pipePkg::OpW-1:0] idOp,
	output logic [pipePkg::RegAddrW-1:0] idRs,
	output logic [pipePkg::RegAddrW-1:0] idRt,
	output logic [pipePkg::RegAddrW-1:0] idRd,
	output logic [pipePkg::DataW-1:0] idImm,
	output logic idRfWr,
	output logic idMemRd
);
	logic [pipePkg::InstW-1:0] idInst;
	logic readyEn;
	logic accept;
	logic writesRd;

	assign instReady = idWr & readyEn;	// Stall closes the input
	assign accept = instValid & instReady;

	always_ff @(posedge clk) begin
		if (rst_sign) begin
			readyEn <= 1'b0;
			idValid <= 1'b0;
		end else begin
			readyEn <= 1'b1;
			if (idWr) begin
				idValid <= accept;	// Empty slot when nothing arrives
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			idInst <= instWord;
		end
	end

	assign idOp = idInst[pipePkg::OpMsb -: pipePkg::OpW];
	assign idRd = idInst[pipePkg::RdLsb +: pipePkg::RegAddrW];
	assign idRs = idInst[pipePkg::RsLsb +: pipePkg::RegAddrW];
	assign idRt = idInst[pipePkg::RtLsb +: pipePkg::RegAddrW];
	assign idImm = {{(pipePkg::DataW - pipePkg::ImmW){idInst[pipePkg::ImmW-1]}},
		idInst[pipePkg::ImmW-1:0]};

	assign writesRd = (idOp == pipePkg::OpAdd) || (idOp == pipePkg::OpSub) ||
		(idOp == pipePkg::OpAddi) || (idOp == pipePkg::OpLw);
	assign idRfWr = idValid && writesRd && (idRd != '0);	// r0 is never written
	assign idMemRd = idValid && (idOp == pipePkg::OpLw);

	idHoldChk: assert property (@(posedge clk) disable iff (rst_sign)
		!idWr |=> $stable(idValid))
		else $error("ID stage changed while frozen");

endmodule

`default_nettype wire

// File: hdl/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
	input wire clk,
	input wire rst_sign,
	input wire [pipePkg::RegAddrW-1:0] rdAddrA,
	input wire [pipePkg::RegAddrW-1:0] rdAddrB,
	output logic [pipePkg::DataW-1:0] rdDataA,
	output logic [pipePkg::DataW-1:0] rdDataB,
	input wire wrEn,
	input wire [pipePkg::RegAddrW-1:0] wrAddr,
	input wire [pipePkg::DataW-1:0] wrData
);
	localparam int Entries = 2 ** pipePkg::RegAddrW;

	logic [pipePkg::DataW-1:0] regs [Entries];

	always_ff @(posedge clk) begin
		if (rst_sign) begin
			for (int i = 0; i < Entries; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn && (wrAddr != '0)) begin
			regs[wrAddr] <= wrData;
		end
	end

	// WB value seen by ID in the same cycle
	assign rdDataA = (rdAddrA == '0) ? '0 :
		(wrEn && (wrAddr == rdAddrA)) ? wrData : regs[rdAddrA];
	assign rdDataB = (rdAddrB == '0) ? '0 :
		(wrEn && (wrAddr == rdAddrB)) ? wrData : regs[rdAddrB];

endmodule

`default_nettype wire

// File: hdl/bypass.sv
`timescale 1ns/1ps
`default_nettype none

module bypass (
	input wire [pipePkg::RegAddrW-1:0] exRs,
	input wire [pipePkg::RegAddrW-1:0] exRt,
	input wire [pipePkg::RegAddrW-1:0] mem1Rd,
	input wire [pipePkg::RegAddrW-1:0] mem2Rd,
	input wire [pipePkg::RegAddrW-1:0] wbRd,
	input wire mem1RfWr,
	input wire mem1MemRd,
	input wire mem2RfWr,
	input wire wbRfWr,
	output logic [1:0] fwdASel,
	output logic [1:0] fwdBSel
);

	function automatic logic [1:0] pickSrc(input logic [pipePkg::RegAddrW-1:0] src);
		if (mem1RfWr && !mem1MemRd && (mem1Rd != '0) && (mem1Rd == src))
			pickSrc = pipePkg::FwdMem1;	// ALU result only
		else if (mem2RfWr && (mem2Rd != '0) && (mem2Rd == src))
			pickSrc = pipePkg::FwdMem2;
		else if (wbRfWr && (wbRd != '0) && (wbRd == src))
			pickSrc = pipePkg::FwdWb;
		else
			pickSrc = pipePkg::FwdNone;
	endfunction

	always_comb begin
		fwdASel = pickSrc(exRs);
		fwdBSel = pickSrc(exRt);
		// Load data only exists from MEM2 on
		assert (!(mem1MemRd && (fwdASel == pipePkg::FwdMem1)))
			else $error("Operand A forwarded from a load in MEM1");
	end

endmodule

`default_nettype wire

// File: hdl/stall.sv
`timescale 1ns/1ps
`default_nettype none

module stall (
	input wire idValid,
	input wire [pipePkg::RegAddrW-1:0] idRs,
	input wire [pipePkg::RegAddrW-1:0] idRt,
	input wire [pipePkg::RegAddrW-1:0] exRd,
	input wire exMemRd,
	input wire [pipePkg::RegAddrW-1:0] mem1Rd,
	input wire mem1MemRd,
	output logic idWr,
	output logic exBubble
);
	logic stall0;
	logic stall1;

	always_comb begin
		// Load in EX, two cycles until its data reaches MEM2
		stall0 = idValid && exMemRd && (exRd != '0) &&
			((exRd == idRs) || (exRd == idRt));
		// Load in MEM1, one cycle left
		stall1 = idValid && mem1MemRd && (mem1Rd != '0) &&
			((mem1Rd == idRs) || (mem1Rd == idRt));
		idWr = !(stall0 || stall1);
		exBubble = stall0 || stall1;
		assert (!(idWr && exBubble))
			else $error("Bubble inserted while ID advances");
	end

endmodule

`default_nettype wire

// File: hdl/execPipe.sv
`timescale 1ns/1ps
`default_nettype none

module execPipe #(
	parameter int MemDepth = 16
) (
	input wire clk,
	input wire rst_sign,
	input wire idValid,
	input wire [pipePkg::OpW-1:0] idOp,
	input wire [pipePkg::RegAddrW-1:0] idRs,
	input wire [pipePkg::RegAddrW-1:0] idRt,
	input wire [pipePkg::RegAddrW-1:0] idRd,
	input wire [pipePkg::DataW-1:0] idImm,
	input wire idRfWr,
	input wire idMemRd,
	input wire [pipePkg::DataW-1:0] rdDataA,
	input wire [pipePkg::DataW-1:0] rdDataB,
	input wire exBubble,
	input wire [1:0] fwdASel,
	input wire [1:0] fwdBSel,
	output logic [pipePkg::RegAddrW-1:0] exRs,
	output logic [pipePkg::RegAddrW-1:0] exRt,
	output logic [pipePkg::RegAddrW-1:0] exRd,
	output logic exRfWr,
	output logic exMemRd,
	output logic [pipePkg::RegAddrW-1:0] mem1Rd,
	output logic mem1RfWr,
	output logic mem1MemRd,
	output logic [pipePkg::RegAddrW-1:0] mem2Rd,
	output logic mem2RfWr,
	output logic [pipePkg::RegAddrW-1:0] wbRd,
	output logic wbRfWr,
	output logic [pipePkg::DataW-1:0] wbData
);
	localparam int AddrW = $clog2(MemDepth);

	logic [pipePkg::OpW-1:0] exOp;
	logic [pipePkg::DataW-1:0] exA, exB, exImm;
	logic exMemWr;
	logic [pipePkg::DataW-1:0] opA, opB, aluOut;
	logic mem1MemWr;
	logic [pipePkg::DataW-1:0] mem1Alu, mem1Store;
	logic [pipePkg::DataW-1:0] mem2Data;
	logic [pipePkg::DataW-1:0] scratch [MemDepth];
	logic [AddrW-1:0] memAddr;

	function automatic logic [pipePkg::DataW-1:0] fwdMux(input logic [1:0] sel,
		input logic [pipePkg::DataW-1:0] regVal);
		case (sel)
			pipePkg::FwdMem1: fwdMux = mem1Alu;
			pipePkg::FwdMem2: fwdMux = mem2Data;
			pipePkg::FwdWb: fwdMux = wbData;
			default: fwdMux = regVal;
		endcase
	endfunction

	always_ff @(posedge clk) begin
		if (rst_sign || exBubble) begin
			exRfWr <= 1'b0;
			exMemRd <= 1'b0;
			exMemWr <= 1'b0;
		end else begin
			exRfWr <= idRfWr;
			exMemRd <= idMemRd;
			exMemWr <= idValid && (idOp == pipePkg::OpSw);
		end
	end

	always_ff @(posedge clk) begin
		exOp <= exBubble ? pipePkg::OpNop : idOp;
		exRs <= idRs;
		exRt <= idRt;
		exRd <= idRd;
		exA <= rdDataA;
		exB <= rdDataB;
		exImm <= idImm;
	end

	always_comb begin
		opA = fwdMux(fwdASel, exA);
		opB = fwdMux(fwdBSel, exB);	// Also the SW store data
		case (exOp)
			pipePkg::OpAdd: aluOut = opA + opB;
			pipePkg::OpSub: aluOut = opA - opB;
			default: aluOut = opA + exImm;	// ADDI and address generation
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst_sign) begin
			mem1RfWr <= 1'b0;
			mem1MemRd <= 1'b0;
			mem1MemWr <= 1'b0;
			mem2RfWr <= 1'b0;
			wbRfWr <= 1'b0;
		end else begin
			mem1RfWr <= exRfWr;
			mem1MemRd <= exMemRd;
			mem1MemWr <= exMemWr;
			mem2RfWr <= mem1RfWr;
			wbRfWr <= mem2RfWr;
		end
	end

	always_ff @(posedge clk) begin
		mem1Rd <= exRd;
		mem1Alu <= aluOut;
		mem1Store <= opB;
		mem2Rd <= mem1Rd;
		mem2Data <= mem1MemRd ? scratch[memAddr] : mem1Alu;	// Load data registered here
		wbRd <= mem2Rd;
		wbData <= mem2Data;
	end

	assign memAddr = mem1Alu[AddrW-1:0];	// Word index wraps at MemDepth

	always_ff @(posedge clk) begin
		if (mem1MemWr) begin
			scratch[memAddr] <= mem1Store;
		end
	end

endmodule

`default_nettype wire

// File: hdl/commitPort.sv
`timescale 1ns/1ps
`default_nettype none

module commitPort (
	input wire clk,
	input wire rst_sign,
	input wire [pipePkg::RegAddrW-1:0] wbRd,
	input wire wbRfWr,
	input wire [pipePkg::DataW-1:0] wbData,
	output logic commitValid,
	output logic [pipePkg::RegAddrW-1:0] commitRd,
	output logic [pipePkg::DataW-1:0] commitData
);

	always_ff @(posedge clk) begin
		if (rst_sign) begin
			commitValid <= 1'b0;
		end else begin
			commitValid <= wbRfWr;	// One strobe per retired write
		end
	end

	always_ff @(posedge clk) begin
		commitRd <= wbRd;
		commitData <= wbData;
	end

endmodule

`default_nettype wire

// File: hdl/hazardCore.sv
`timescale 1ns/1ps
`default_nettype none

module hazardCore #(
	parameter int MemDepth = 16
) (
	input wire clk,
	input wire rst_sign,
	input wire instValid,
	input wire [pipePkg::InstW-1:0] instWord,
	output logic instReady,
	output logic commitValid,
	output logic [pipePkg::RegAddrW-1:0] commitRd,
	output logic [pipePkg::DataW-1:0] commitData
);
	logic idValid;
	logic [pipePkg::OpW-1:0] idOp;
	logic [pipePkg::RegAddrW-1:0] idRs, idRt, idRd;
	logic [pipePkg::DataW-1:0] idImm;
	logic idRfWr, idMemRd;
	logic [pipePkg::DataW-1:0] rdDataA, rdDataB;
	logic idWr, exBubble;
	logic [1:0] fwdASel, fwdBSel;
	logic [pipePkg::RegAddrW-1:0] exRs, exRt, exRd;
	logic exRfWr, exMemRd;
	logic [pipePkg::RegAddrW-1:0] mem1Rd, mem2Rd, wbRd;
	logic mem1RfWr, mem1MemRd, mem2RfWr, wbRfWr;
	logic [pipePkg::DataW-1:0] wbData;

	instDecode uDecode (.*);

	regFile uRegFile (
		.clk(clk),
		.rst_sign(rst_sign),
		.rdAddrA(idRs),
		.rdAddrB(idRt),
		.rdDataA(rdDataA),
		.rdDataB(rdDataB),
		.wrEn(wbRfWr),
		.wrAddr(wbRd),
		.wrData(wbData)
	);

	stall uStall (.*);

	bypass uBypass (.*);

	execPipe #(
		.MemDepth(MemDepth)
	) uExec (.*);

	commitPort uCommit (.*);

endmodule

`default_nettype wire

// File: bench/refModel.svh
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

function automatic logic [pipePkg::InstW-1:0] encInst(input logic [3:0] op,
	input logic [4:0] rd, input logic [4:0] rs, input logic [4:0] rt,
	input logic [12:0] imm);
	encInst = {op, rd, rs, rt, imm};	// op, rd, rs, rt, imm from MSB down
endfunction

task automatic modelReset();
	for (int i = 0; i < 32; i++) begin
		modelRegs[i] = '0;
	end
	for (int i = 0; i < MemDepth; i++) begin
		modelMem[i] = '0;
	end
	expRd.delete();
	expData.delete();
	expEdge.delete();
endtask

// Architectural effect of one accepted instruction
task automatic modelStep(input logic [pipePkg::InstW-1:0] inst, input int accEdge);
	logic [3:0] op;
	logic [4:0] rd;
	logic [4:0] rs;
	logic [4:0] rt;
	logic [31:0] imm;
	logic [31:0] ea;
	logic [31:0] res;
	logic [AddrW-1:0] addr;
	logic wr;
	op = inst[31:28];
	rd = inst[27:23];
	rs = inst[22:18];
	rt = inst[17:13];
	imm = {{19{inst[12]}}, inst[12:0]};
	ea = modelRegs[rs] + imm;
	addr = ea[AddrW-1:0];	// Word address modulo MemDepth
	wr = 1'b1;
	res = '0;
	case (op)
		pipePkg::OpAdd: res = modelRegs[rs] + modelRegs[rt];
		pipePkg::OpSub: res = modelRegs[rs] - modelRegs[rt];
		pipePkg::OpAddi: res = ea;
		pipePkg::OpLw: res = modelMem[addr];
		pipePkg::OpSw: begin
			modelMem[addr] = modelRegs[rt];
			wr = 1'b0;
		end
		default: wr = 1'b0;
	endcase
	if (wr && (rd != '0)) begin	// r0 stays zero and never commits
		modelRegs[rd] = res;
		expRd.push_back(rd);
		expData.push_back(res);
		expEdge.push_back(accEdge);
	end
endtask

`endif

// File: bench/hazardCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module hazardCoreTb;
	localparam int MemDepth = 16;
	localparam int AddrW = $clog2(MemDepth);
	localparam int Period = 10;
	localparam int RandInst = 200;
	localparam int NumInst = 2 * MemDepth + 27 + RandInst;	// Memory fill, then directed and random
	localparam int DrainLimit = 20;

	logic clk;
	logic rst_sign;
	logic instValid;
	logic [pipePkg::InstW-1:0] instWord;
	logic instReady;
	logic commitValid;
	logic [pipePkg::RegAddrW-1:0] commitRd;
	logic [pipePkg::DataW-1:0] commitData;

	logic [pipePkg::DataW-1:0] modelRegs [32];
	logic [pipePkg::DataW-1:0] modelMem [MemDepth];
	logic [pipePkg::RegAddrW-1:0] expRd [$];
	logic [pipePkg::DataW-1:0] expData [$];
	int expEdge [$];

	int seed;
	int edgeNum = 0;
	int valErrors = 0;
	int otherErrors = 0;
	int readyLowCnt = 0;
	logic checkLat = 1'b0;
	logic [3:0] rndOp;
	logic [4:0] rndRd;
	logic [4:0] rndRs;
	logic [4:0] rndRt;
	logic [12:0] rndImm;

	`include "refModel.svh"

	hazardCore #(
		.MemDepth(MemDepth)
	) DUT (
		.clk(clk),
		.rst_sign(rst_sign),
		.instValid(instValid),
		.instWord(instWord),
		.instReady(instReady),
		.commitValid(commitValid),
		.commitRd(commitRd),
		.commitData(commitData)
	);

	initial begin
		clk = 1'b0;
		forever #(Period / 2) clk = ~clk;
	end

	always @(posedge clk) edgeNum <= edgeNum + 1;

	task automatic checkCommit();
		assert (expRd.size() > 0) else begin
			otherErrors++;
			$display("Commit strobe for r%0d with no instruction pending", commitRd);
		end
		if (expRd.size() > 0) begin
			assert (commitRd === expRd[0]) else begin
				valErrors++;
				$display("Fail commitRd expected %h got %h", expRd[0], commitRd);
			end
			assert (commitData === expData[0]) else begin
				valErrors++;
				$display("Fail commitData expected %h got %h", expData[0], commitData);
			end
			assert (!checkLat || (edgeNum - expEdge[0] == 5)) else begin
				otherErrors++;
				$display("Commit came %0d edges after acceptance, not 5", edgeNum - expEdge[0]);
			end
			void'(expRd.pop_front());
			void'(expData.pop_front());
			void'(expEdge.pop_front());
		end
	endtask

	// Outputs are stable at the falling edge
	always @(negedge clk) begin
		if (!rst_sign) begin
			if (!instReady) readyLowCnt++;
			if (commitValid) checkCommit();
			if (instValid && instReady) modelStep(instWord, edgeNum + 1);	// Taken next edge
		end
	end

	task automatic sendInst(input logic [pipePkg::InstW-1:0] word);
		instValid = 1'b1;
		instWord = word;
		@(negedge clk);
		while (!instReady) @(negedge clk);
		@(posedge clk);
		#1;
		instValid = 1'b0;
	endtask

	task automatic idleCycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic drainPipe();
		int waited;
		waited = 0;
		while ((expRd.size() != 0) && (waited < DrainLimit)) begin
			@(negedge clk);
			waited++;
		end
		idleCycles(8);	// Room for any stray strobe
	endtask

	initial begin
		seed = 22362;
		rst_sign = 1'b1;
		instValid = 1'b0;
		instWord = '0;
		modelReset();
		repeat (5) @(posedge clk);
		#1;
		rst_sign = 1'b0;
		for (int i = 0; i < MemDepth; i++) begin
			// Address-dependent fill of the scratch memory
			sendInst(encInst(pipePkg::OpAddi, 5'd1, 5'd0, 5'd0, 13'(i) ^ 13'h15a5));
			sendInst(encInst(pipePkg::OpSw, 5'd0, 5'd0, 5'd1, 13'(i)));
		end
		drainPipe();

		checkLat = 1'b1;
		sendInst(encInst(pipePkg::OpAddi, 5'd1, 5'd0, 5'd0, 13'd100));
		sendInst(encInst(pipePkg::OpAddi, 5'd2, 5'd0, 5'd0, 13'd23));
		sendInst(encInst(pipePkg::OpAddi, 5'd3, 5'd0, 5'd0, -13'd7));
		sendInst(encInst(pipePkg::OpAddi, 5'd4, 5'd0, 5'd0, 13'h0fff));
		repeat (4) sendInst('0);
		sendInst(encInst(pipePkg::OpAdd, 5'd5, 5'd1, 5'd2, 13'd0));
		sendInst(encInst(pipePkg::OpAdd, 5'd6, 5'd3, 5'd4, 13'd0));
		drainPipe();

		sendInst(encInst(pipePkg::OpAddi, 5'd10, 5'd0, 5'd0, 13'd11));
		sendInst(encInst(pipePkg::OpAddi, 5'd11, 5'd0, 5'd0, -13'd4));
		sendInst(encInst(pipePkg::OpSub, 5'd12, 5'd10, 5'd11, 13'd0));	// MEM2 and MEM1
		sendInst(encInst(pipePkg::OpAdd, 5'd13, 5'd12, 5'd10, 13'd0));	// MEM1 and WB
		sendInst('0);
		sendInst(encInst(pipePkg::OpAdd, 5'd14, 5'd13, 5'd12, 13'd0));	// MEM2 and WB
		drainPipe();
		checkLat = 1'b0;

		sendInst(encInst(pipePkg::OpAddi, 5'd1, 5'd0, 5'd0, 13'd77));
		sendInst(encInst(pipePkg::OpSw, 5'd0, 5'd0, 5'd1, 13'd3));
		drainPipe();
		readyLowCnt = 0;
		sendInst(encInst(pipePkg::OpLw, 5'd2, 5'd0, 5'd0, 13'd3));
		sendInst(encInst(pipePkg::OpAdd, 5'd3, 5'd2, 5'd2, 13'd0));
		drainPipe();
		assert (readyLowCnt == 2) else begin
			otherErrors++;
			$display("instReady low %0d cycles for an adjacent load use, 2 expected", readyLowCnt);
		end
		readyLowCnt = 0;
		sendInst(encInst(pipePkg::OpLw, 5'd4, 5'd0, 5'd0, 13'd3));
		sendInst(encInst(pipePkg::OpAddi, 5'd5, 5'd0, 5'd0, 13'd1));
		sendInst(encInst(pipePkg::OpSub, 5'd6, 5'd4, 5'd5, 13'd0));
		drainPipe();
		assert (readyLowCnt == 1) else begin
			otherErrors++;
			$display("instReady low %0d cycles for a load use one apart, 1 expected", readyLowCnt);
		end

		sendInst(encInst(pipePkg::OpAddi, 5'd0, 5'd0, 5'd0, 13'd5));
		sendInst(encInst(pipePkg::OpAdd, 5'd7, 5'd0, 5'd0, 13'd0));
		sendInst(encInst(pipePkg::OpLw, 5'd0, 5'd0, 5'd0, 13'd3));
		sendInst(encInst(pipePkg::OpAddi, 5'd9, 5'd0, 5'd0, 13'd1));
		drainPipe();

		for (int i = 0; i < RandInst; i++) begin
			rndOp = 4'({$random(seed)} % 6);
			rndRd = 5'({$random(seed)} % 8);	// Few registers for many hazards
			rndRs = 5'({$random(seed)} % 8);
			rndRt = 5'({$random(seed)} % 8);
			rndImm = 13'($random(seed));
			idleCycles(int'({$random(seed)} % 3));
			sendInst(encInst(rndOp, rndRd, rndRs, rndRt, rndImm));
		end
		drainPipe();
		assert (expRd.size() == 0) else begin
			otherErrors++;
			$display("%0d expected commits never arrived", expRd.size());
		end

		$display("Errors: %0d value mismatches, %0d other failures", valErrors, otherErrors);
		if ((valErrors == 0) && (otherErrors == 0))
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

	initial begin
		#(Period * 20 * (NumInst + 10));
		$display("Timeout: the pipeline stopped accepting or committing instructions");
		$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
+incdir+bench
hdl/pipePkg.sv
hdl/instDecode.sv
hdl/regFile.sv
hdl/bypass.sv
hdl/stall.sv
hdl/execPipe.sv
hdl/commitPort.sv
hdl/hazardCore.sv
bench/hazardCoreTb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS = --timing --assert
TOP = hazardCoreTb
FLIST = flist.f
OBJDIR = obj_dir
PASS_MSG = Result: PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
